// File: design/apb_mem_port.sv
module apb_mem_port (
    input  logic                  sda,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eeprom_pkg::mem_addr_t paddr,
    input  eeprom_pkg::mem_data_t pwdata,
    output eeprom_pkg::mem_data_t prdata,
    output logic                  pready,
    output logic                  cpu_req,
    output logic                  cpu_we,
    output eeprom_pkg::mem_addr_t cpu_addr,
    output eeprom_pkg::mem_data_t cpu_wdata,
    input  eeprom_pkg::mem_data_t cpu_rdata,
    input  logic                  cpu_gnt
);

    logic setup_phase;

    assign setup_phase = psel & ~penable;

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cpu_req <= 1'b0;
            pready  <= 1'b0;
        end
        else
        begin
            // request lives from first access cycle until granted
            if (cpu_gnt)
                cpu_req <= 1'b0;
            else if (setup_phase)
                cpu_req <= 1'b1;
            pready <= cpu_gnt;
        end
    end

    // latch the transfer in the setup phase
    always_ff @(posedge sda)
    begin
        if (setup_phase)
        begin
            cpu_we    <= pwrite;
            cpu_addr  <= paddr;
            cpu_wdata <= pwdata;
        end
    end

    // store holds cpu_rdata until the next granted access
    assign prdata = cpu_rdata;

    a_penable_needs_psel: assert property (@(posedge sda) disable iff (!arst_n)
        penable |-> psel);

endmodule

// File: design/eeprom_pkg.sv
package eeprom_pkg;

    // storage geometry
    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 8;
    localparam int PAGE_W    = 3;
    localparam int MEM_DEPTH = 2048;

    // page bits on top, word byte below
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;
    typedef logic [PAGE_W-1:0] page_t;

    // serial target states
    typedef enum logic [3:0] {
        st_idle        = 4'd0,
        st_control     = 4'd1,
        st_control_ack = 4'd2,
        st_word_addr   = 4'd3,
        st_addr_ack    = 4'd4,
        st_write_data  = 4'd5,
        st_write_ack   = 4'd6,
        st_read_data   = 4'd7,
        st_read_ack    = 4'd8,
        st_ignore      = 4'd9
    } serial_state_e;

    // device type code in the upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE_DEFAULT = 4'b1010;

endpackage

// File: design/eeprom_store.sv
module eeprom_store (
    input  logic                  sda,
    input  logic                  arst_n,
    input  logic                  ser_req,
    input  logic                  ser_we,
    input  eeprom_pkg::mem_addr_t ser_addr,
    input  eeprom_pkg::mem_data_t ser_wdata,
    output eeprom_pkg::mem_data_t ser_rdata,
    input  logic                  cpu_req,
    input  logic                  cpu_we,
    input  eeprom_pkg::mem_addr_t cpu_addr,
    input  eeprom_pkg::mem_data_t cpu_wdata,
    output eeprom_pkg::mem_data_t cpu_rdata,
    output logic                  cpu_gnt
);

    import eeprom_pkg::*;

    mem_data_t mem [MEM_DEPTH];

    logic      port_en;
    logic      port_we;
    mem_addr_t port_addr;
    mem_data_t port_wdata;
    mem_data_t rd_q;
    logic      ser_pend;
    logic      cpu_pend;
    mem_data_t ser_keep;
    mem_data_t cpu_keep;

    // serial always wins over a waiting cpu
    assign cpu_gnt = cpu_req & ~ser_req;

    assign port_en    = ser_req | cpu_req;
    assign port_we    = ser_req ? ser_we : cpu_we;
    assign port_addr  = ser_req ? ser_addr : cpu_addr;
    assign port_wdata = ser_req ? ser_wdata : cpu_wdata;

    // single port array with read before write
    always_ff @(posedge sda)
    begin
        if (port_en)
        begin
            if (port_we)
                mem[port_addr] <= port_wdata;
            rd_q <= mem[port_addr];
        end
    end

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ser_pend <= 1'b0;
            cpu_pend <= 1'b0;
        end
        else
        begin
            ser_pend <= ser_req;
            cpu_pend <= cpu_gnt;
        end
    end

    // hold each port's last read until its next access
    always_ff @(posedge sda)
    begin
        if (ser_pend)
            ser_keep <= rd_q;
        if (cpu_pend)
            cpu_keep <= rd_q;
    end

    assign ser_rdata = ser_pend ? rd_q : ser_keep;
    assign cpu_rdata = cpu_pend ? rd_q : cpu_keep;

    // a serial access holds the port for one cycle only
    a_ser_one_cycle: assert property (@(posedge sda) disable iff (!arst_n)
        ser_req |=> !ser_req);

    // apb side must keep asking until it is served
    a_cpu_req_held: assert property (@(posedge sda) disable iff (!arst_n)
        (cpu_req && !cpu_gnt) |=> cpu_req);

endmodule

// File: design/eeprom_top.sv
module eeprom_top #(
    parameter logic [3:0] device_code = eeprom_pkg::DEVICE_CODE_DEFAULT
) (
    input  logic                  sda,
    input  logic                  arst_n,
    input  logic                  scl,
    input  logic                  sdio_in,
    output logic                  sdio_pull_low,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eeprom_pkg::mem_addr_t paddr,
    input  eeprom_pkg::mem_data_t pwdata,
    output eeprom_pkg::mem_data_t prdata,
    output logic                  pready
);

    import eeprom_pkg::*;

    logic      scl_rise;
    logic      scl_fall;
    logic      sdio_bit;
    logic      start_seen;
    logic      stop_seen;
    logic      ser_req;
    logic      ser_we;
    mem_addr_t ser_addr;
    mem_data_t ser_wdata;
    mem_data_t ser_rdata;
    logic      cpu_req;
    logic      cpu_we;
    mem_addr_t cpu_addr;
    mem_data_t cpu_wdata;
    mem_data_t cpu_rdata;
    logic      cpu_gnt;

    serial_line_sync u_sync (
        .sda        (sda),
        .arst_n     (arst_n),
        .scl        (scl),
        .sdio_in    (sdio_in),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .sdio_bit   (sdio_bit),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    serial_target_fsm #(
        .device_code (device_code)
    ) u_target (
        .sda           (sda),
        .arst_n        (arst_n),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .sdio_bit      (sdio_bit),
        .start_seen    (start_seen),
        .stop_seen     (stop_seen),
        .sdio_pull_low (sdio_pull_low),
        .ser_req       (ser_req),
        .ser_we        (ser_we),
        .ser_addr      (ser_addr),
        .ser_wdata     (ser_wdata),
        .ser_rdata     (ser_rdata)
    );

    apb_mem_port u_apb (
        .sda       (sda),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_gnt   (cpu_gnt)
    );

    eeprom_store u_store (
        .sda       (sda),
        .arst_n    (arst_n),
        .ser_req   (ser_req),
        .ser_we    (ser_we),
        .ser_addr  (ser_addr),
        .ser_wdata (ser_wdata),
        .ser_rdata (ser_rdata),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_gnt   (cpu_gnt)
    );

endmodule

// File: design/serial_line_sync.sv
module serial_line_sync (
    input  logic sda,
    input  logic arst_n,
    input  logic scl,
    input  logic sdio_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic sdio_bit,
    output logic start_seen,
    output logic stop_seen
);

    logic [1:0] scl_sync;
    logic [1:0] sdio_sync;
    logic       scl_q;
    logic       sdio_q;
    logic       scl_s;
    logic       sdio_s;

    // bus idles high, so reset everything to one
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scl_sync  <= 2'b11;
            sdio_sync <= 2'b11;
            scl_q     <= 1'b1;
            sdio_q    <= 1'b1;
        end
        else
        begin
            scl_sync  <= {scl_sync[0], scl};
            sdio_sync <= {sdio_sync[0], sdio_in};
            scl_q     <= scl_s;
            sdio_q    <= sdio_s;
        end
    end

    assign scl_s  = scl_sync[1];
    assign sdio_s = sdio_sync[1];

    assign scl_rise = scl_s & ~scl_q;
    assign scl_fall = ~scl_s & scl_q;
    assign sdio_bit = sdio_s;

    // data edges only count while scl stays high
    assign start_seen = scl_s & scl_q & sdio_q & ~sdio_s;
    assign stop_seen  = scl_s & scl_q & ~sdio_q & sdio_s;

endmodule

// File: design/serial_target_fsm.sv
module serial_target_fsm #(
    parameter logic [3:0] device_code = eeprom_pkg::DEVICE_CODE_DEFAULT
) (
    input  logic                  sda,
    input  logic                  arst_n,
    input  logic                  scl_rise,
    input  logic                  scl_fall,
    input  logic                  sdio_bit,
    input  logic                  start_seen,
    input  logic                  stop_seen,
    output logic                  sdio_pull_low,
    output logic                  ser_req,
    output logic                  ser_we,
    output eeprom_pkg::mem_addr_t ser_addr,
    output eeprom_pkg::mem_data_t ser_wdata,
    input  eeprom_pkg::mem_data_t ser_rdata
);

    import eeprom_pkg::*;

    serial_state_e state;
    logic [3:0]    bit_cnt;
    logic          read_mode;
    logic          receiving;
    logic          byte_done;
    logic          code_ok;
    logic          tx_bit;
    mem_data_t     shift_q;
    mem_data_t     word_q;
    mem_data_t     wdata_q;
    mem_data_t     tx_q;
    page_t         page_q;

    assign receiving = (state == st_control) || (state == st_word_addr) ||
                       (state == st_write_data);
    assign byte_done = (bit_cnt == 4'd8);
    assign code_ok   = (shift_q[7:4] == device_code);

    // first bit comes straight from the store, the rest from the shifter
    assign tx_bit = (bit_cnt == 4'd0) ? ser_rdata[7] : tx_q[7];

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state         <= st_idle;
            bit_cnt       <= 4'd0;
            read_mode     <= 1'b0;
            sdio_pull_low <= 1'b0;
            ser_req       <= 1'b0;
            ser_we        <= 1'b0;
        end
        else
        begin
            ser_req <= 1'b0;
            if (start_seen)
            begin
                state         <= st_control;
                bit_cnt       <= 4'd0;
                sdio_pull_low <= 1'b0;
            end
            else if (stop_seen)
            begin
                state         <= st_idle;
                sdio_pull_low <= 1'b0;
            end
            else if (scl_rise)
            begin
                if (receiving && !byte_done)
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (scl_fall)
            begin
                case (state)
                    st_control:
                        if (byte_done)
                        begin
                            if (code_ok)
                            begin
                                state         <= st_control_ack;
                                sdio_pull_low <= 1'b1;
                                read_mode     <= shift_q[0];
                            end
                            else
                                state <= st_ignore;
                        end
                    st_control_ack:
                    begin
                        sdio_pull_low <= 1'b0;
                        bit_cnt       <= 4'd0;
                        if (read_mode)
                        begin
                            // random read, fetch the byte now
                            state   <= st_read_data;
                            ser_req <= 1'b1;
                            ser_we  <= 1'b0;
                        end
                        else
                            state <= st_word_addr;
                    end
                    st_word_addr:
                        if (byte_done)
                        begin
                            state         <= st_addr_ack;
                            sdio_pull_low <= 1'b1;
                        end
                    st_addr_ack:
                    begin
                        sdio_pull_low <= 1'b0;
                        bit_cnt       <= 4'd0;
                        state         <= st_write_data;
                    end
                    st_write_data:
                        if (byte_done)
                        begin
                            state         <= st_write_ack;
                            sdio_pull_low <= 1'b1;
                        end
                    st_write_ack:
                    begin
                        // single byte only, then wait for stop
                        sdio_pull_low <= 1'b0;
                        ser_req       <= 1'b1;
                        ser_we        <= 1'b1;
                        state         <= st_ignore;
                    end
                    st_read_data:
                        if (byte_done)
                        begin
                            sdio_pull_low <= 1'b0;
                            state         <= st_read_ack;
                        end
                        else
                        begin
                            sdio_pull_low <= ~tx_bit;
                            bit_cnt       <= bit_cnt + 4'd1;
                        end
                    st_read_ack:
                        state <= st_ignore;
                    default:
                        state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (scl_rise && receiving && !byte_done)
            shift_q <= {shift_q[6:0], sdio_bit};
        if (scl_fall && byte_done)
        begin
            if (state == st_control && code_ok)
                page_q <= shift_q[3:1];
            if (state == st_word_addr)
                word_q <= shift_q;
            if (state == st_write_data)
                wdata_q <= shift_q;
        end
        if (scl_fall && state == st_read_data && !byte_done)
        begin
            if (bit_cnt == 4'd0)
                tx_q <= {ser_rdata[6:0], 1'b0};
            else
                tx_q <= {tx_q[6:0], 1'b0};
        end
    end

    // page and word survive a repeated start
    assign ser_addr  = {page_q, word_q};
    assign ser_wdata = wdata_q;

    a_pull_only_when_driving: assert property (@(posedge sda) disable iff (!arst_n)
        sdio_pull_low |-> state inside {st_control_ack, st_addr_ack, st_write_ack,
                                        st_read_data});

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module eeprom_tb -o eeprom_sim

# the simulator exit code is not trusted, the log decides
./obj_dir/eeprom_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

// File: sources.f
design/eeprom_pkg.sv
design/serial_line_sync.sv
design/serial_target_fsm.sv
design/apb_mem_port.sv
design/eeprom_store.sv
design/eeprom_top.sv
test/eeprom_tb.sv

// File: test/eeprom_tb.sv
module eeprom_tb;

    import eeprom_pkg::*;

    localparam int        apb_timeout = 64;
    localparam logic [3:0] bad_code   = 4'b0110;

    typedef enum logic [2:0] {
        op_apb_write,
        op_apb_read,
        op_ser_write,
        op_ser_read,
        op_ser_bad
    } op_e;

    typedef struct packed {
        op_e        op;
        page_t      page;
        logic [7:0] word;
        mem_data_t  data;
        mem_data_t  exp_data;
        logic       exp_ack;
    } row_t;

    logic      sda;
    logic      arst_n;
    logic      scl;
    logic      sdio_in = 1'b1;
    logic      sdio_pull_low;
    logic      host_sda;
    logic      psel;
    logic      penable;
    logic      pwrite;
    mem_addr_t paddr;
    mem_data_t pwdata;
    mem_data_t prdata;
    logic      pready;
    logic      ser_busy;

    integer    seed = 32'h5faa9048;
    mem_data_t model [MEM_DEPTH];
    row_t      rows [$];

    eeprom_top #(
        .device_code (DEVICE_CODE_DEFAULT)
    ) dut0 (
        .sda           (sda),
        .arst_n        (arst_n),
        .scl           (scl),
        .sdio_in       (sdio_in),
        .sdio_pull_low (sdio_pull_low),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready)
    );

    initial
    begin
        sda = 1'b0;
        forever #4 sda = ~sda;
    end

    // open drain line is low if either side pulls
    always @(posedge sda)
        sdio_in <= host_sda & ~sdio_pull_low;

    task automatic check_byte(input string what, input mem_data_t got, input mem_data_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_ack(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %03h expected %03h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // one bit is 16 clocks with scl high for the middle 8
    task automatic clock_bit(input logic b, output logic seen);
        host_sda <= b;
        repeat (4) @(posedge sda);
        scl <= 1'b1;
        repeat (4) @(posedge sda);
        @(negedge sda);
        seen = sdio_in;
        repeat (4) @(posedge sda);
        scl <= 1'b0;
        repeat (4) @(posedge sda);
    endtask

    task automatic clock_ack(output logic acked);
        acked = 1'b0;
        host_sda <= 1'b1;
        repeat (4) @(posedge sda);
        scl <= 1'b1;
        // the high phase bounds the wait
        for (int k = 0; k < 8; k++)
        begin
            @(negedge sda);
            if (!sdio_in)
                acked = 1'b1;
        end
        @(posedge sda);
        scl <= 1'b0;
        repeat (4) @(posedge sda);
    endtask

    task automatic start_cond();
        host_sda <= 1'b1;
        repeat (4) @(posedge sda);
        scl <= 1'b1;
        repeat (4) @(posedge sda);
        host_sda <= 1'b0;
        repeat (4) @(posedge sda);
        scl <= 1'b0;
        repeat (4) @(posedge sda);
    endtask

    task automatic stop_cond();
        host_sda <= 1'b0;
        repeat (4) @(posedge sda);
        scl <= 1'b1;
        repeat (4) @(posedge sda);
        host_sda <= 1'b1;
        repeat (8) @(posedge sda);
    endtask

    task automatic send_byte(input mem_data_t value, output logic acked);
        logic spare;
        for (int i = 7; i >= 0; i--)
            clock_bit(value[i], spare);
        clock_ack(acked);
    endtask

    task automatic serial_write(input logic [3:0] code, input page_t page, input logic [7:0] word,
                                input mem_data_t data, output logic ack_ctl,
                                output logic ack_word, output logic ack_data);
        start_cond();
        send_byte({code, page, 1'b0}, ack_ctl);
        send_byte(word, ack_word);
        send_byte(data, ack_data);
        stop_cond();
    endtask

    task automatic serial_read(input page_t page, input logic [7:0] word, output mem_data_t data,
                               output logic ack_ctl, output logic ack_word, output logic ack_rd);
        logic spare;
        logic bit_seen;
        start_cond();
        send_byte({DEVICE_CODE_DEFAULT, page, 1'b0}, ack_ctl);
        send_byte(word, ack_word);
        start_cond();
        send_byte({DEVICE_CODE_DEFAULT, page, 1'b1}, ack_rd);
        // target puts out bit 7 one clock after its ack
        clock_bit(1'b1, spare);
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, bit_seen);
            data[i] = bit_seen;
        end
        // host nack ends the read
        clock_bit(1'b1, spare);
        stop_cond();
    endtask

    task automatic apb_transfer(input logic we, input mem_addr_t addr, input mem_data_t wdata,
                                output mem_data_t rdata);
        int waited;
        @(posedge sda);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= we;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge sda);
        penable <= 1'b1;
        waited = 0;
        @(negedge sda);
        while (!pready)
        begin
            if (waited == apb_timeout)
            begin
                $display("timeout: pready never came for address %03h at %0t", addr, $time);
                $display("test failed");
                $fatal(1, "APB transfer hung");
            end
            waited++;
            @(negedge sda);
        end
        rdata = prdata;
        @(posedge sda);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic mem_data_t next_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // expected values come from the model as rows are added
    function automatic void add_row(input op_e op, input page_t page, input logic [7:0] word);
        row_t      r;
        mem_addr_t addr;
        addr       = {page, word};
        r.op       = op;
        r.page     = page;
        r.word     = word;
        r.data     = next_byte();
        r.exp_ack  = (op != op_ser_bad);
        r.exp_data = model[addr];
        if (op == op_apb_write || op == op_ser_write)
        begin
            model[addr] = r.data;
            r.exp_data  = r.data;
        end
        rows.push_back(r);
    endfunction

    task automatic apply_row(input row_t r);
        mem_addr_t addr;
        mem_data_t rd;
        logic      a0;
        logic      a1;
        logic      a2;
        addr = {r.page, r.word};
        case (r.op)
            op_apb_write:
                apb_transfer(1'b1, addr, r.data, rd);
            op_apb_read:
            begin
                apb_transfer(1'b0, addr, '0, rd);
                check_byte("prdata", rd, r.exp_data);
            end
            op_ser_write, op_ser_bad:
            begin
                serial_write((r.op == op_ser_bad) ? bad_code : DEVICE_CODE_DEFAULT,
                             r.page, r.word, r.data, a0, a1, a2);
                check_ack("control ack", a0, r.exp_ack);
                check_ack("word ack", a1, r.exp_ack);
                check_ack("data ack", a2, r.exp_ack);
                if (r.op == op_ser_write)
                    check_addr("ser_addr", dut0.ser_addr, addr);
            end
            op_ser_read:
            begin
                serial_read(r.page, r.word, rd, a0, a1, a2);
                check_ack("control ack", a0, 1'b1);
                check_ack("word ack", a1, 1'b1);
                check_ack("read control ack", a2, 1'b1);
                check_byte("sdio_pull_low byte", rd, r.exp_data);
                check_addr("ser_addr", dut0.ser_addr, addr);
            end
            default:
            begin
                $display("unknown row kind in the stimulus table");
                $display("test failed");
                $fatal(1, "bad table row");
            end
        endcase
    endtask

    initial
    begin
        integer    n;
        mem_data_t d;
        mem_data_t wd;
        mem_data_t rd;
        logic      a0;
        logic      a1;
        logic      a2;
        arst_n   = 1'b0;
        scl      = 1'b1;
        host_sda = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        ser_busy = 1'b0;
        repeat (16) @(posedge sda);
        arst_n <= 1'b1;
        repeat (4) @(posedge sda);

        add_row(op_apb_write, 3'd0, 8'h10);
        add_row(op_apb_read,  3'd0, 8'h10);
        add_row(op_ser_write, 3'd1, 8'h22);
        add_row(op_apb_read,  3'd1, 8'h22);
        add_row(op_apb_write, 3'd2, 8'h33);
        add_row(op_ser_read,  3'd2, 8'h33);
        add_row(op_ser_bad,   3'd0, 8'h10);
        add_row(op_apb_read,  3'd0, 8'h10);
        add_row(op_ser_write, 3'd3, 8'h44);
        add_row(op_ser_write, 3'd4, 8'h44);
        add_row(op_ser_read,  3'd3, 8'h44);
        add_row(op_ser_read,  3'd4, 8'h44);
        add_row(op_apb_read,  3'd3, 8'h44);
        add_row(op_apb_read,  3'd4, 8'h44);
        foreach (rows[i])
            apply_row(rows[i]);

        // back to back APB writes while a serial write runs
        d = next_byte();
        model[{3'd5, 8'h5a}] = d;
        ser_busy = 1'b1;
        n = 0;
        fork
            begin
                serial_write(DEVICE_CODE_DEFAULT, 3'd5, 8'h5a, d, a0, a1, a2);
                ser_busy = 1'b0;
            end
            begin
                // one clock of offset puts a cpu request on the serial write pulse
                @(posedge sda);
                while (ser_busy)
                begin
                    wd = next_byte();
                    model[{3'd6, n[7:0]}] = wd;
                    apb_transfer(1'b1, {3'd6, n[7:0]}, wd, rd);
                    n++;
                end
            end
        join
        check_ack("control ack", a0, 1'b1);
        check_ack("word ack", a1, 1'b1);
        check_ack("data ack", a2, 1'b1);
        check_addr("ser_addr", dut0.ser_addr, {3'd5, 8'h5a});
        for (int i = 0; i < n; i++)
        begin
            apb_transfer(1'b0, {3'd6, i[7:0]}, '0, rd);
            check_byte("prdata", rd, model[{3'd6, i[7:0]}]);
        end
        apb_transfer(1'b0, {3'd5, 8'h5a}, '0, rd);
        check_byte("prdata", rd, model[{3'd5, 8'h5a}]);
        serial_read(3'd6, 8'h00, rd, a0, a1, a2);
        check_ack("read control ack", a2, 1'b1);
        check_byte("sdio_pull_low byte", rd, model[{3'd6, 8'h00}]);

        $display("test passed");
        $finish;
    end

endmodule
